// ==== rtl/rv32_branch_predictor.sv ====
`default_nettype none

module rv32_branch_predictor
    import rv32_pkg::*;
(
    input  word_t instr,
    output logic  branch_predicted_taken,
    output addr_t branch_offset
);

    opcode_t opcode;
    logic    sign;
    addr_t   imm_j;
    addr_t   imm_b;

    assign opcode = instr[6:0];
    assign sign   = instr[31];

    // J-type immediate, bit 0 is always zero.
    assign imm_j = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // B-type immediate.
    assign imm_b = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    ////////////////////////////////////////
    // Static prediction
    ////////////////////////////////////////

    always_comb begin
        if (opcode == OPCODE_JAL) begin
            branch_predicted_taken = 1'b1;         // Jumps always taken.
            branch_offset          = imm_j;
        end else if (opcode == OPCODE_BRANCH && sign) begin
            branch_predicted_taken = 1'b1;         // Backward branch, loop guess.
            branch_offset          = imm_b;
        end else begin
            branch_predicted_taken = 1'b0;
            branch_offset          = 32'd4;        // Fall through.
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv32_fetch.sv ====
`default_nettype none

module rv32_fetch
    import rv32_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   pcgen_stall,
    input  logic   stall,
    input  logic   flush,
    input  logic   trap,
    input  logic   branch_mispredicted,
    input  logic   instr_fault,
    input  logic   branch_predicted_taken,
    input  addr_t  trap_pc,
    input  addr_t  branch_pc,
    input  addr_t  branch_offset,
    input  word_t  instr_read_value,
    output logic   overwrite_pc,
    output logic   valid,
    output logic   exception,
    output cause_t exception_cause,
    output logic   branch_predicted_taken_out,
    output addr_t  pc,
    output word_t  instr,
    output addr_t  instr_address
);

    addr_t fetch_pc = RESET_VECTOR;   // Known value before the first reset edge.
    addr_t next_pc;
    addr_t redirect_pc;
    logic  latch_redirect;

    assign instr_address = fetch_pc;

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    // Only the first request during a PC stall is kept.
    assign latch_redirect = pcgen_stall && !overwrite_pc && (trap || branch_mispredicted);

    always_comb begin
        if (overwrite_pc)
            next_pc = redirect_pc;
        else if (trap)
            next_pc = trap_pc;
        else if (branch_mispredicted)
            next_pc = branch_pc;
        else
            next_pc = fetch_pc + branch_offset;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc     <= RESET_VECTOR;
            overwrite_pc <= 1'b0;
        end else if (pcgen_stall) begin
            if (latch_redirect)
                overwrite_pc <= 1'b1;      // Applied once the stall lifts.
        end else begin
            overwrite_pc <= 1'b0;
            fetch_pc     <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (latch_redirect)
            redirect_pc <= trap ? trap_pc : branch_pc;   // Trap wins.
    end

    ////////////////////////////////////////
    // Fetch output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid                      <= 1'b0;
            exception                  <= 1'b0;
            exception_cause            <= '0;
            branch_predicted_taken_out <= 1'b0;
            instr                      <= INSTR_NOP;
            pc                         <= '0;
        end else if (!stall) begin
            if (flush) begin
                valid                      <= 1'b0;
                exception                  <= 1'b0;
                branch_predicted_taken_out <= 1'b0;
                instr                      <= INSTR_NOP;
                pc                         <= '0;
            end else if (instr_fault) begin
                valid                      <= 1'b0;
                exception                  <= 1'b1;
                exception_cause            <= MCAUSE_INSTR_FAULT;
                branch_predicted_taken_out <= 1'b0;
                instr                      <= '0;
                pc                         <= fetch_pc;   // Faulting address.
            end else begin
                valid                      <= 1'b1;
                exception                  <= 1'b0;
                branch_predicted_taken_out <= branch_predicted_taken;
                instr                      <= instr_read_value;
                pc                         <= fetch_pc;
            end
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    a_valid_xor_exception: assert property (@(posedge clk) disable iff (reset)
        !(valid && exception));

    a_valid_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        valid |-> (pc[1:0] == 2'b00));

    // A redirect can only become pending out of a PC stall.
    a_overwrite_from_stall: assert property (@(posedge clk) disable iff (reset)
        $rose(overwrite_pc) |-> $past(pcgen_stall));

endmodule

`default_nettype wire

// ==== rtl/rv32_frontend.sv ====
`default_nettype none

module rv32_frontend
    import rv32_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   pcgen_stall,
    input  logic   stall,
    input  logic   flush,
    input  logic   trap,
    input  addr_t  trap_pc,
    input  logic   branch_mispredicted,
    input  addr_t  branch_pc,
    output logic   overwrite_pc,
    output logic   valid,
    output logic   exception,
    output cause_t exception_cause,
    output logic   branch_predicted_taken,
    output addr_t  pc,
    output word_t  instr
);

    addr_t instr_address;
    word_t instr_read_value;
    logic  instr_fault;
    logic  predicted_taken;   // Prediction for the word being fetched.
    addr_t branch_offset;

    rv32_fetch u_fetch (
        .clk                        (clk),
        .reset                      (reset),
        .pcgen_stall                (pcgen_stall),
        .stall                      (stall),
        .flush                      (flush),
        .trap                       (trap),
        .branch_mispredicted        (branch_mispredicted),
        .instr_fault                (instr_fault),
        .branch_predicted_taken     (predicted_taken),
        .trap_pc                    (trap_pc),
        .branch_pc                  (branch_pc),
        .branch_offset              (branch_offset),
        .instr_read_value           (instr_read_value),
        .overwrite_pc               (overwrite_pc),
        .valid                      (valid),
        .exception                  (exception),
        .exception_cause            (exception_cause),
        .branch_predicted_taken_out (branch_predicted_taken),
        .pc                         (pc),
        .instr                      (instr),
        .instr_address              (instr_address)
    );

    rv32_branch_predictor u_predictor (
        .instr                  (instr_read_value),
        .branch_predicted_taken (predicted_taken),
        .branch_offset          (branch_offset)
    );

    rv32_instr_mem u_imem (
        .clk              (clk),
        .instr_address    (instr_address),
        .instr_read_value (instr_read_value),
        .instr_fault      (instr_fault)
    );

endmodule

`default_nettype wire

// ==== rtl/rv32_instr_mem.sv ====
`default_nettype none

module rv32_instr_mem
    import rv32_pkg::*;
(
    input  logic  clk,
    input  addr_t instr_address,
    output word_t instr_read_value,
    output logic  instr_fault
);

    word_t rom [IMEM_WORDS];

    logic [IMEM_INDEX_BITS-1:0] word_index;
    logic                       misaligned;
    logic                       out_of_range;

    initial begin
        $readmemh("program.hex", rom);
    end

    ////////////////////////////////////////
    // Combinational read
    ////////////////////////////////////////

    assign word_index   = instr_address[IMEM_INDEX_BITS+1:2];
    assign misaligned   = instr_address[1:0] != 2'b00;
    assign out_of_range = (instr_address >> 2) >= addr_t'(IMEM_WORDS);

    assign instr_fault = misaligned || out_of_range;

    // Faulting fetches return zero.
    assign instr_read_value = instr_fault ? '0 : rom[word_index];

    // The PC feeding this port is expected to be defined on every edge.
    a_address_known: assert property (@(posedge clk)
        !$isunknown(instr_address));

endmodule

`default_nettype wire

// ==== rtl/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

    ////////////////////////////////////////
    // Word types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;    // Instruction or data word.
    typedef logic [31:0] addr_t;    // Byte address or PC value.
    typedef logic [6:0]  opcode_t;  // Major opcode field.
    typedef logic [3:0]  cause_t;   // Exception cause code.

    ////////////////////////////////////////
    // Opcodes and instructions
    ////////////////////////////////////////

    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;

    // ADDI x0, x0, 0
    localparam word_t INSTR_NOP = 32'h0000_0013;

    ////////////////////////////////////////
    // Exception causes
    ////////////////////////////////////////

    localparam cause_t MCAUSE_INSTR_FAULT = 4'd1;  // Instruction access fault.

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////

    localparam addr_t RESET_VECTOR = 32'h0000_0000;

    localparam int IMEM_WORDS      = 64;                   // ROM size in words.
    localparam int IMEM_INDEX_BITS = $clog2(IMEM_WORDS);   // Word index width.

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the front end testbench with Verilator and run it.
# The ROM loads program.hex from the working directory, so the run starts in verification/.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module rv32_frontend_tb \
    -Mdir obj_dir || { echo "Verilator build failed"; exit 1; }
out=$(cd verification && ../obj_dir/Vrv32_frontend_tb)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1

// ==== verification/program.hex ====
// ROM image, one 32-bit instruction word per line, starting at address 0x00.
00000013
00100013
00200013
00000463
00400013
00c0006f
00600013
00700013
00800013
fe000ce3
00a00013
00b00013
00c00013
00d00013
00e00013
00f00013
01000013
01100013
01200013
01300013

// ==== verification/rv32_frontend_tb.sv ====
`default_nettype none

module rv32_frontend_tb
    import rv32_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_FILLERS  = 4;    // Extra stall cycles, kept inside the watchdog margin.
    localparam int SEED         = 68;

    localparam addr_t BEYOND_ROM = addr_t'(IMEM_WORDS * 4);   // First byte past the ROM.

    typedef struct {
        logic [4:0] ctrl;       // pcgen_stall, stall, flush, trap, branch_mispredicted.
        addr_t      trap_pc;
        addr_t      branch_pc;
        logic [3:0] flags;      // valid, exception, branch_predicted_taken, overwrite_pc.
        cause_t     cause;
        addr_t      pc;
        logic       filler_ok;  // Straight-line row, a held cycle may go before it.
    } row_t;

    logic   clk;
    logic   reset;
    logic   pcgen_stall;
    logic   stall;
    logic   flush;
    logic   trap;
    addr_t  trap_pc;
    logic   branch_mispredicted;
    addr_t  branch_pc;
    logic   overwrite_pc;
    logic   valid;
    logic   exception;
    cause_t exception_cause;
    logic   branch_predicted_taken;
    addr_t  pc;
    word_t  instr;

    row_t  rows [$];
    word_t program_words [32];   // Known ROM image for the instr column.
    int    errors = 0;
    int    checks = 0;

    rv32_frontend DUT (
        .clk                    (clk),
        .reset                  (reset),
        .pcgen_stall            (pcgen_stall),
        .stall                  (stall),
        .flush                  (flush),
        .trap                   (trap),
        .trap_pc                (trap_pc),
        .branch_mispredicted    (branch_mispredicted),
        .branch_pc              (branch_pc),
        .overwrite_pc           (overwrite_pc),
        .valid                  (valid),
        .exception              (exception),
        .exception_cause        (exception_cause),
        .branch_predicted_taken (branch_predicted_taken),
        .pc                     (pc),
        .instr                  (instr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_cause(input string name, input cause_t actual, input cause_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    // Word i is ADDI x0,x0,i except for the branch and jump slots.
    task automatic load_program_image();
        for (int i = 0; i < 32; i++)
            program_words[i] = {12'(i), 20'h00013};
        program_words[3] = 32'h0000_0463;   // BEQ +8, forward.
        program_words[5] = 32'h00C0_006F;   // JAL +12.
        program_words[9] = 32'hFE00_0CE3;   // BEQ -8, backward.
    endtask

    task automatic add_row(input logic [4:0] ctrl, input addr_t trap_target,
                           input addr_t branch_target, input logic [3:0] flags,
                           input cause_t cause, input addr_t pc_value, input logic filler_ok);
        row_t r;
        r.ctrl      = ctrl;
        r.trap_pc   = trap_target;
        r.branch_pc = branch_target;
        r.flags     = flags;
        r.cause     = cause;
        r.pc        = pc_value;
        r.filler_ok = filler_ok;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // ctrl      trap_pc   branch_pc  flags    cause  pc        filler
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h000, 1'b0);  // Reset vector.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h004, 1'b1);
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h008, 1'b1);
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h00C, 1'b1);  // Forward BEQ.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h010, 1'b1);
        add_row(5'b00000, 32'h000, 32'h000, 4'b1010, 4'd0, 32'h014, 1'b1);  // JAL.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h020, 1'b1);
        add_row(5'b00000, 32'h000, 32'h000, 4'b1010, 4'd0, 32'h024, 1'b1);  // Backward BEQ.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h01C, 1'b1);
        add_row(5'b00010, 32'h008, 32'h000, 4'b1000, 4'd0, 32'h020, 1'b0);  // Trap.
        add_row(5'b00001, 32'h000, 32'h010, 4'b1000, 4'd0, 32'h008, 1'b0);  // Mispredict.
        add_row(5'b00011, 32'h004, 32'h028, 4'b1000, 4'd0, 32'h010, 1'b0);  // Both, trap wins.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h004, 1'b1);
        add_row(5'b10010, 32'h02C, 32'h000, 4'b1001, 4'd0, 32'h008, 1'b0);  // Latched.
        add_row(5'b10001, 32'h000, 32'h000, 4'b1001, 4'd0, 32'h008, 1'b0);  // Ignored.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h008, 1'b0);  // Release.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h02C, 1'b1);
        add_row(5'b11000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h02C, 1'b0);  // Both stalls.
        add_row(5'b01000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h02C, 1'b0);  // PC runs on.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd0, 32'h034, 1'b1);
        add_row(5'b00100, 32'h000, 32'h000, 4'b0000, 4'd0, 32'h000, 1'b0);  // Flush.
        add_row(5'b00010, BEYOND_ROM, 32'h000, 4'b1000, 4'd0, 32'h03C, 1'b0);
        add_row(5'b00010, 32'h032, 32'h000, 4'b0100, 4'd1, BEYOND_ROM, 1'b0);  // Beyond ROM.
        add_row(5'b00010, BEYOND_ROM, 32'h000, 4'b0100, 4'd1, 32'h032, 1'b0);  // Misaligned.
        add_row(5'b00110, 32'h000, 32'h000, 4'b0000, 4'd1, 32'h000, 1'b0);  // Fault flushed.
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd1, 32'h000, 1'b1);
        add_row(5'b00000, 32'h000, 32'h000, 4'b1000, 4'd1, 32'h004, 1'b1);
    endtask

    ////////////////////////////////////////
    // Row driving and checking
    ////////////////////////////////////////

    function automatic word_t expected_instr(input row_t r);
        if (r.flags[3])
            return program_words[r.pc[6:2]];
        else if (r.flags[2])
            return '0;                      // Faulting fetch.
        else
            return INSTR_NOP;               // Reset or flush.
    endfunction

    task automatic check_outputs(input row_t r);
        check_flag("valid", valid, r.flags[3]);
        check_flag("exception", exception, r.flags[2]);
        check_cause("exception_cause", exception_cause, r.cause);
        check_flag("branch_predicted_taken", branch_predicted_taken, r.flags[1]);
        check_flag("overwrite_pc", overwrite_pc, r.flags[0]);
        check_addr("pc", pc, r.pc);
        check_word("instr", instr, expected_instr(r));
    endtask

    task automatic apply_row(input row_t r);
        {pcgen_stall, stall, flush, trap, branch_mispredicted} = r.ctrl;
        trap_pc   = r.trap_pc;
        branch_pc = r.branch_pc;
        @(posedge clk);
        #DRIVE_DELAY;
        check_outputs(r);
    endtask

    initial begin
        row_t hold;
        int   fillers;
        fillers             = 0;
        reset               = 1'b1;
        pcgen_stall         = 1'b0;
        stall               = 1'b0;
        flush               = 1'b0;
        trap                = 1'b0;
        trap_pc             = '0;
        branch_mispredicted = 1'b0;
        branch_pc           = '0;
        void'($urandom(SEED));
        load_program_image();
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        hold.flags = 4'b0000;
        hold.cause = '0;
        hold.pc    = '0;
        check_outputs(hold);                // Reset values.

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].filler_ok && fillers < MAX_FILLERS && ($urandom % 4) == 0) begin
                hold           = rows[i - 1];
                hold.ctrl      = 5'b11000;  // Everything holds for one cycle.
                hold.trap_pc   = '0;
                hold.branch_pc = '0;
                apply_row(hold);
                fillers++;
            end
            apply_row(rows[i]);
        end

        $display("Checks: %0d, errors: %0d, filler stalls: %0d", checks, errors, fillers);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #1;
        #((RESET_CYCLES + rows.size() + 10) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in the expected number of cycles.");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/rv32_pkg.sv
rtl/rv32_branch_predictor.sv
rtl/rv32_fetch.sv
rtl/rv32_instr_mem.sv
rtl/rv32_frontend.sv
verification/rv32_frontend_tb.sv
